// ==== msx_params.svh ====
`ifndef MSX_PARAMS_SVH
`define MSX_PARAMS_SVH

// PPI occupies four consecutive I/O ports
`define MSX_PPI_BASE  8'hA8
`define MSX_PPI_PORTS 4

// Value seen on an undriven data bus
`define MSX_OPEN_BUS  8'hFF

// Keyboard matrix geometry
`define MSX_KBD_ROWS  11

// Audio sample width
`define MSX_AUDIO_W   16

`endif

// ==== msx_bus_pkg.sv ====
`default_nettype none

package msx_bus_pkg;

   // Device selected by the current I/O cycle
   typedef enum logic [1:0] {
      IO_NONE = 2'd0,
      IO_PPI  = 2'd1
   } io_dev_t;

   // Where the CPU read data comes from
   typedef enum logic [1:0] {
      SRC_IDLE    = 2'd0,
      SRC_PPI     = 2'd1,
      SRC_IO_OPEN = 2'd2,
      SRC_MEM     = 2'd3
   } rd_src_t;

endpackage

`default_nettype wire

// ==== msx_slot_pkg.sv ====
`default_nettype none

package msx_slot_pkg;

   // Primary slot number
   typedef logic [1:0] slot_t;

   // PPI output registers
   typedef struct packed {
      logic [7:0] port_a;
      logic [7:0] port_c;
      logic [7:0] mode;
   } ppi_regs_t;

   // One key press or release
   typedef struct packed {
      logic       pressed;
      logic [3:0] row;
      logic [2:0] col;
   } key_event_t;

endpackage

`default_nettype wire

// ==== cpu_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;
   logic [15:0] addr;
   logic [7:0]  wdata;
   logic        mreq;
   logic        iorq;
   logic        rd;
   logic        wr;
   logic        m1;
   // One-cycle request and PPI chip select, both from the decoder
   logic        req;
   logic        ppi_sel;

   modport decoder (
      input  addr, wdata, mreq, iorq, rd, wr, m1,
      output req, ppi_sel
   );

   modport device (
      input addr, wdata, mreq, iorq, rd, wr, m1, req, ppi_sel
   );
endinterface

`default_nettype wire

// ==== msx_io_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "msx_params.svh"

module msx_io_decoder (
   input  wire logic       clock_bus,
   input  wire logic       reset,
   cpu_bus_if.decoder      bus,
   input  wire logic [7:0] ppi_rdata,
   input  wire logic [7:0] mem_data,
   output logic      [7:0] data_out
);
   import msx_bus_pkg::*;

   localparam logic [7:0] PPI_FIRST = `MSX_PPI_BASE;
   localparam logic [7:0] PPI_LAST  = `MSX_PPI_BASE + `MSX_PPI_PORTS - 1;

   io_dev_t io_dev;
   rd_src_t rd_src;
   logic    ack_q;
   logic    bus_active;

   // Only the low address byte counts for I/O, interrupt acknowledge is ignored
   always_comb begin
      io_dev = IO_NONE;
      if (bus.iorq && !bus.m1 && bus.addr[7:0] >= PPI_FIRST && bus.addr[7:0] <= PPI_LAST) begin
         io_dev = IO_PPI;
      end
   end

   assign bus.ppi_sel = (io_dev == IO_PPI);

   assign bus_active = (bus.iorq || bus.mreq) && (bus.rd || bus.wr) && !bus.m1;
   assign bus.req    = bus_active && !ack_q;

   // Held until both strobes drop so each cycle gets one request
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else if (!bus.iorq && !bus.mreq) begin
         ack_q <= 1'b0;
      end else if (bus.req) begin
         ack_q <= 1'b1;
      end
   end

   always_comb begin
      if (!bus.rd) begin
         rd_src = SRC_IDLE;
      end else if (io_dev == IO_PPI) begin
         rd_src = SRC_PPI;
      end else if (bus.iorq) begin
         rd_src = SRC_IO_OPEN;
      end else if (bus.mreq) begin
         rd_src = SRC_MEM;
      end else begin
         rd_src = SRC_IDLE;
      end
   end

   always_comb begin
      case (rd_src)
         SRC_PPI: data_out = ppi_rdata;
         SRC_MEM: data_out = mem_data;
         default: data_out = `MSX_OPEN_BUS;
      endcase
   end

   // A bus cycle never gets two requests back to back
   a_req_single: assert property (@(posedge clock_bus) disable iff (reset)
      bus.req |=> !bus.req);

   a_ppi_sel_iorq: assert property (@(posedge clock_bus) disable iff (reset)
      bus.ppi_sel |-> bus.iorq);

endmodule

`default_nettype wire

// ==== msx_ppi.sv ====
`timescale 1ns/1ps
`default_nettype none

module msx_ppi (
   input  wire logic             clock_bus,
   input  wire logic             reset,
   cpu_bus_if.device             bus,
   input  wire logic [7:0]       portb_in,
   output msx_slot_pkg::ppi_regs_t regs,
   output logic      [7:0]       rdata,
   output logic                  touched
);
   import msx_slot_pkg::*;

   ppi_regs_t regs_q;
   logic      wr_en;

   assign touched = bus.req && bus.ppi_sel;
   assign wr_en   = touched && bus.wr;

   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         regs_q.port_a <= 8'h00;
         regs_q.port_c <= 8'h00;
         regs_q.mode   <= 8'h9B;
      end else if (wr_en) begin
         case (bus.addr[1:0])
            2'd0: regs_q.port_a <= bus.wdata;
            2'd2: regs_q.port_c <= bus.wdata;
            2'd3: begin
               if (bus.wdata[7]) begin
                  regs_q.mode <= bus.wdata;
               end else begin
                  // Bit set/reset on port C
                  regs_q.port_c[bus.wdata[3:1]] <= bus.wdata[0];
               end
            end
            // Port B is input only in the MSX wiring
            default: ;
         endcase
      end
   end

   assign regs = regs_q;

   always_comb begin
      case (bus.addr[1:0])
         2'd0:    rdata = regs_q.port_a;
         2'd1:    rdata = portb_in;
         2'd2:    rdata = regs_q.port_c;
         default: rdata = regs_q.mode;
      endcase
   end

   // Writing port B leaves every register as it was
   a_no_portb_write: assert property (@(posedge clock_bus) disable iff (reset)
      (wr_en && bus.addr[1:0] == 2'd1) |=> $stable(regs_q));

endmodule

`default_nettype wire

// ==== msx_slot_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module msx_slot_select (
   input  wire logic                      clock_bus,
   input  wire logic                      reset,
   cpu_bus_if.device                      bus,
   input  wire msx_slot_pkg::ppi_regs_t   regs,
   input  wire logic                      touched,
   output msx_slot_pkg::slot_t            active_slot
);
   import msx_slot_pkg::*;

   logic  map_valid;
   slot_t page_slot;

   // Slot map is trusted only once software has touched the PPI
   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         map_valid <= 1'b0;
      end else if (touched) begin
         map_valid <= 1'b1;
      end
   end

   // Each 16K page has its own 2-bit field in port A
   always_comb begin
      case (bus.addr[15:14])
         2'd0:    page_slot = regs.port_a[1:0];
         2'd1:    page_slot = regs.port_a[3:2];
         2'd2:    page_slot = regs.port_a[5:4];
         default: page_slot = regs.port_a[7:6];
      endcase
   end

   assign active_slot = map_valid ? page_slot : 2'd0;

endmodule

`default_nettype wire

// ==== msx_keyboard_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "msx_params.svh"

module msx_keyboard_matrix (
   input  wire logic                       clock_bus,
   input  wire logic                       reset,
   input  wire logic                       key_strobe,
   input  wire msx_slot_pkg::key_event_t   key_event,
   input  wire logic [3:0]                 row_sel,
   output logic      [7:0]                 row_data
);
   import msx_slot_pkg::*;

   localparam int ROWS = `MSX_KBD_ROWS;

   // Active low, a pressed key reads as 0
   logic [7:0] key_q [ROWS];
   key_event_t ev;

   assign ev = key_event;

   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         for (int r = 0; r < ROWS; r++) begin
            key_q[r] <= 8'hFF;
         end
      end else if (key_strobe && ev.row < ROWS) begin
         key_q[ev.row][ev.col] <= ~ev.pressed;
      end
   end

   // Rows past the end of the matrix float high
   always_comb begin
      if (row_sel < ROWS) begin
         row_data = key_q[row_sel];
      end else begin
         row_data = `MSX_OPEN_BUS;
      end
   end

endmodule

`default_nettype wire

// ==== msx_audio_mix.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "msx_params.svh"

module msx_audio_mix (
   input  wire logic                           clock_bus,
   input  wire logic                           reset,
   input  wire logic                           keybeep,
   input  wire logic                           cas_motor,
   input  wire logic                           cas_audio_in,
   input  wire logic signed [`MSX_AUDIO_W-1:0] device_sound,
   output logic             [`MSX_AUDIO_W-1:0] audio
);
   localparam int W = `MSX_AUDIO_W;

   localparam logic signed [W:0] CLIP_HI   = 8191;
   localparam logic signed [W:0] CLIP_LO   = -8192;
   localparam logic signed [W:0] BEEP_LVL  = 512;
   localparam logic signed [W:0] CAS_LVL   = 256;
   localparam logic signed [W:0] ZERO      = '0;

   logic signed [W:0] sum;
   logic signed [W:0] clipped;

   // Cassette input is only heard while the motor relay is off
   assign sum = {device_sound[W-1], device_sound}
              + (keybeep ? BEEP_LVL : ZERO)
              + ((cas_audio_in && !cas_motor) ? CAS_LVL : ZERO);

   assign clipped = (sum > CLIP_HI) ? CLIP_HI :
                    (sum < CLIP_LO) ? CLIP_LO : sum;

   always_ff @(posedge clock_bus or posedge reset) begin
      if (reset) begin
         audio <= '0;
      end else begin
         audio <= {clipped[W-2:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

// ==== msx_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "msx_params.svh"

module msx_io_top (
   input  wire logic                     clock_bus,
   input  wire logic                     reset,
   input  wire logic [15:0]              addr,
   input  wire logic [7:0]               data_in,
   output logic      [7:0]               data_out,
   input  wire logic                     mreq,
   input  wire logic                     iorq,
   input  wire logic                     rd,
   input  wire logic                     wr,
   input  wire logic                     m1,
   input  wire logic [7:0]               mem_data,
   input  wire logic                     key_strobe,
   input  wire logic                     key_pressed,
   input  wire logic [3:0]               key_row,
   input  wire logic [2:0]               key_col,
   input  wire logic                     cas_audio_in,
   input  wire logic [`MSX_AUDIO_W-1:0]  device_sound,
   output logic      [`MSX_AUDIO_W-1:0]  audio,
   output logic                          cas_motor,
   output logic      [1:0]               active_slot
);
   import msx_slot_pkg::*;

   cpu_bus_if bus ();

   ppi_regs_t  ppi_regs;
   key_event_t key_event;
   logic [7:0] ppi_rdata;
   logic [7:0] kbd_row_data;
   logic       ppi_touched;
   logic       keybeep;

   assign bus.addr  = addr;
   assign bus.wdata = data_in;
   assign bus.mreq  = mreq;
   assign bus.iorq  = iorq;
   assign bus.rd    = rd;
   assign bus.wr    = wr;
   assign bus.m1    = m1;

   assign key_event = '{pressed: key_pressed, row: key_row, col: key_col};

   // Port C drives the click, the cassette relay and the row select
   assign keybeep   = ppi_regs.port_c[7];
   assign cas_motor = ppi_regs.port_c[4];

   msx_io_decoder u_decoder (
      .clock_bus (clock_bus),
      .reset     (reset),
      .bus       (bus.decoder),
      .ppi_rdata (ppi_rdata),
      .mem_data  (mem_data),
      .data_out  (data_out)
   );

   msx_ppi u_ppi (
      .clock_bus (clock_bus),
      .reset     (reset),
      .bus       (bus.device),
      .portb_in  (kbd_row_data),
      .regs      (ppi_regs),
      .rdata     (ppi_rdata),
      .touched   (ppi_touched)
   );

   msx_slot_select u_slot (
      .clock_bus   (clock_bus),
      .reset       (reset),
      .bus         (bus.device),
      .regs        (ppi_regs),
      .touched     (ppi_touched),
      .active_slot (active_slot)
   );

   msx_keyboard_matrix u_kbd (
      .clock_bus  (clock_bus),
      .reset      (reset),
      .key_strobe (key_strobe),
      .key_event  (key_event),
      .row_sel    (ppi_regs.port_c[3:0]),
      .row_data   (kbd_row_data)
   );

   msx_audio_mix u_audio (
      .clock_bus    (clock_bus),
      .reset        (reset),
      .keybeep      (keybeep),
      .cas_motor    (cas_motor),
      .cas_audio_in (cas_audio_in),
      .device_sound (device_sound),
      .audio        (audio)
   );

endmodule

`default_nettype wire

// ==== tb_msx_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_msx_checker (
   input wire logic        clock_bus,
   input wire logic        reset,
   input wire logic [7:0]  data_out,
   input wire logic [15:0] audio,
   input wire logic        cas_motor,
   input wire logic [1:0]  active_slot
);

   int check_count = 0;
   int error_count = 0;

   task automatic compare_value(input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
      end
   endtask

   // Sampled on the rising edge, half a cycle after the stimulus settles
   always @(posedge clock_bus) begin
      if (!reset) begin
         if (tb_msx_io.exp_data_en) begin
            compare_value("data_out", {8'h00, data_out}, {8'h00, tb_msx_io.exp_data});
         end
         if (tb_msx_io.exp_slot_en) begin
            compare_value("active_slot", {14'h0, active_slot}, {14'h0, tb_msx_io.exp_slot});
         end
         if (tb_msx_io.exp_motor_en) begin
            compare_value("cas_motor", {15'h0, cas_motor}, {15'h0, tb_msx_io.exp_motor});
         end
         if (tb_msx_io.exp_audio_en) begin
            compare_value("audio", audio, tb_msx_io.exp_audio);
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb_msx_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_msx_io;

   localparam int N_RW  = 12;
   localparam int N_BSR = 16;
   localparam int N_KEY = 20;
   localparam int N_MUX = 8;
   localparam int N_AUD = 10;
   // One item per loop pass, plus room for resets and the fixed steps
   localparam int N_ITEMS = N_RW + N_BSR + N_KEY + 16 + N_MUX + 4 * (N_AUD + 4) + 24;

   logic        clock_bus = 1'b0;
   logic        reset = 1'b1;
   logic [15:0] addr = '0;
   logic [7:0]  data_in = '0;
   logic [7:0]  data_out;
   logic        mreq = 1'b0;
   logic        iorq = 1'b0;
   logic        rd = 1'b0;
   logic        wr = 1'b0;
   logic        m1 = 1'b0;
   logic [7:0]  mem_data = '0;
   logic        key_strobe = 1'b0;
   logic        key_pressed = 1'b0;
   logic [3:0]  key_row = '0;
   logic [2:0]  key_col = '0;
   logic        cas_audio_in = 1'b0;
   logic [15:0] device_sound = '0;
   logic [15:0] audio;
   logic        cas_motor;
   logic [1:0]  active_slot;

   // Expected values for the checker
   logic        exp_data_en = 1'b0;
   logic [7:0]  exp_data = '0;
   logic        exp_slot_en = 1'b0;
   logic [1:0]  exp_slot = '0;
   logic        exp_motor_en = 1'b0;
   logic        exp_motor = 1'b0;
   logic        exp_audio_en = 1'b0;
   logic [15:0] exp_audio = '0;

   // Reference model state
   logic [31:0] rng_state = 32'h7b1a911d;
   logic [7:0]  ref_port_a;
   logic [7:0]  ref_port_c;
   logic [7:0]  ref_mode;
   logic [7:0]  ref_keys [11];
   logic        ref_map_valid;
   int          tests_run = 0;
   int          errors_before = 0;

   always #10 clock_bus = ~clock_bus;

   msx_io_top UUT (
      .clock_bus    (clock_bus),
      .reset        (reset),
      .addr         (addr),
      .data_in      (data_in),
      .data_out     (data_out),
      .mreq         (mreq),
      .iorq         (iorq),
      .rd           (rd),
      .wr           (wr),
      .m1           (m1),
      .mem_data     (mem_data),
      .key_strobe   (key_strobe),
      .key_pressed  (key_pressed),
      .key_row      (key_row),
      .key_col      (key_col),
      .cas_audio_in (cas_audio_in),
      .device_sound (device_sound),
      .audio        (audio),
      .cas_motor    (cas_motor),
      .active_slot  (active_slot)
   );

   tb_msx_checker u_checker (
      .clock_bus   (clock_bus),
      .reset       (reset),
      .data_out    (data_out),
      .audio       (audio),
      .cas_motor   (cas_motor),
      .active_slot (active_slot)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Port C after a bit set/reset control word
   function automatic logic [7:0] bsr_result(input logic [7:0] port_c, input logic [7:0] ctrl);
      logic [7:0] c;
      c = port_c;
      c[ctrl[3:1]] = ctrl[0];
      return c;
   endfunction

   function automatic logic [7:0] row_expect(input logic [3:0] row);
      if (row > 4'd10) begin
         return 8'hFF;
      end
      return ref_keys[row];
   endfunction

   function automatic logic [1:0] slot_expect(input logic valid, input logic [7:0] port_a,
                                              input logic [1:0] page);
      if (!valid) begin
         return 2'd0;
      end
      return port_a[{page, 1'b0} +: 2];
   endfunction

   function automatic logic [15:0] audio_expect(input logic [15:0] sample, input logic beep,
                                                input logic cas, input logic motor);
      int sum;
      sum = $signed(sample);
      if (beep) begin
         sum = sum + 512;
      end
      if (cas && !motor) begin
         sum = sum + 256;
      end
      if (sum > 8191) begin
         sum = 8191;
      end
      if (sum < -8192) begin
         sum = -8192;
      end
      return 16'(sum * 2);
   endfunction

   // Clears every expectation after one sample edge
   task automatic sample_once();
      @(negedge clock_bus);
      exp_data_en  = 1'b0;
      exp_slot_en  = 1'b0;
      exp_motor_en = 1'b0;
      exp_audio_en = 1'b0;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (5) @(negedge clock_bus);
      reset = 1'b0;
      ref_port_a    = 8'h00;
      ref_port_c    = 8'h00;
      ref_mode      = 8'h9B;
      ref_map_valid = 1'b0;
      for (int k = 0; k < 11; k++) begin
         ref_keys[k] = 8'hFF;
      end
   endtask

   // Write cycle with the strobes held for three cycles
   // Motor is checked one cycle after req
   task automatic io_write(input logic [7:0] port, input logic [7:0] data);
      addr    = {8'h00, port};
      data_in = data;
      iorq    = 1'b1;
      wr      = 1'b1;
      @(negedge clock_bus);
      exp_motor_en = 1'b1;
      exp_motor    = ref_port_c[4];
      exp_data_en  = 1'b1;
      exp_data     = 8'hFF;
      sample_once();
      @(negedge clock_bus);
      iorq = 1'b0;
      wr   = 1'b0;
      @(negedge clock_bus);
   endtask

   task automatic ppi_write(input logic [1:0] reg_sel, input logic [7:0] data);
      ref_map_valid = 1'b1;
      case (reg_sel)
         2'd0: ref_port_a = data;
         2'd2: ref_port_c = data;
         2'd3: begin
            if (data[7]) begin
               ref_mode = data;
            end else begin
               ref_port_c = bsr_result(ref_port_c, data);
            end
         end
         default: ;
      endcase
      io_write({6'b101010, reg_sel}, data);
   endtask

   task automatic io_read(input logic [7:0] port, input logic [7:0] expected);
      addr        = {8'h00, port};
      iorq        = 1'b1;
      rd          = 1'b1;
      exp_data_en = 1'b1;
      exp_data    = expected;
      sample_once();
      repeat (2) @(negedge clock_bus);
      iorq = 1'b0;
      rd   = 1'b0;
      if (port >= 8'hA8 && port <= 8'hAB) begin
         ref_map_valid = 1'b1;
      end
      @(negedge clock_bus);
   endtask

   task automatic mem_read(input logic [15:0] address);
      logic [31:0] r;
      r           = next_random();
      addr        = address;
      mem_data    = r[7:0];
      mreq        = 1'b1;
      rd          = 1'b1;
      exp_data_en = 1'b1;
      exp_data    = r[7:0];
      exp_slot_en = 1'b1;
      exp_slot    = slot_expect(ref_map_valid, ref_port_a, address[15:14]);
      sample_once();
      repeat (2) @(negedge clock_bus);
      mreq = 1'b0;
      rd   = 1'b0;
      @(negedge clock_bus);
   endtask

   task automatic send_key(input logic pressed, input logic [3:0] row, input logic [2:0] col);
      key_strobe  = 1'b1;
      key_pressed = pressed;
      key_row     = row;
      key_col     = col;
      @(negedge clock_bus);
      key_strobe = 1'b0;
      if (row <= 4'd10) begin
         ref_keys[row][col] = ~pressed;
      end
   endtask

   // New inputs every cycle, so a registered output lags its sample by one check
   task automatic audio_step(input logic [15:0] sample, input logic cas);
      device_sound = sample;
      cas_audio_in = cas;
      @(negedge clock_bus);
      exp_audio_en = 1'b1;
      exp_audio    = audio_expect(sample, ref_port_c[7], cas, ref_port_c[4]);
   endtask

   task automatic end_test(input string name);
      int errs;
      errs          = u_checker.error_count - errors_before;
      errors_before = u_checker.error_count;
      tests_run++;
      $display("Test %0d, %s: %s, %0d mismatches", tests_run, name,
               (errs == 0) ? "ok" : "mismatch", errs);
   endtask

   initial begin
      logic [31:0] r;
      logic [7:0]  port;
      logic [3:0]  row;
      apply_reset();

      for (int i = 0; i < N_RW; i++) begin
         r = next_random();
         ppi_write(2'd0, r[7:0]);
         io_read(8'hA8, ref_port_a);
         ppi_write(2'd2, r[15:8]);
         ppi_write(2'd1, r[31:24]);
         io_read(8'hAA, ref_port_c);
      end
      io_read(8'hAB, ref_mode);
      end_test("port A and C read back");

      for (int i = 0; i < N_BSR; i++) begin
         r = next_random();
         ppi_write(2'd3, {1'b0, r[6:0]});
         io_read(8'hAA, ref_port_c);
      end
      end_test("port C bit set and reset");

      apply_reset();
      for (int p = 0; p < 4; p++) begin
         r = next_random();
         mem_read({p[1:0], r[13:0]});
      end
      r = next_random();
      ppi_write(2'd0, r[23:16]);
      for (int p = 0; p < 4; p++) begin
         r = next_random();
         mem_read({p[1:0], r[13:0]});
      end
      end_test("primary slot select");

      for (int i = 0; i < N_KEY; i++) begin
         r   = next_random();
         row = r[7:4] % 4'd11;
         send_key(r[0] | r[1], row, r[10:8]);
         ppi_write(2'd2, {r[15:12], row});
         io_read(8'hA9, row_expect(row));
      end
      // Sweep every row select, including the ones past the matrix
      for (int k = 0; k < 16; k++) begin
         ppi_write(2'd2, {4'h0, k[3:0]});
         io_read(8'hA9, row_expect(k[3:0]));
      end
      end_test("keyboard matrix");

      for (int i = 0; i < N_MUX; i++) begin
         r    = next_random();
         port = r[7:0];
         if (port >= 8'hA8 && port <= 8'hAB) begin
            port = port ^ 8'h10;
         end
         io_read(port, 8'hFF);
         io_write(port, r[15:8]);
         mem_read(r[31:16]);
      end
      end_test("read data mux");

      for (int m = 0; m < 4; m++) begin
         ppi_write(2'd3, {4'b0000, 3'd7, m[0]});
         ppi_write(2'd3, {4'b0000, 3'd4, m[1]});
         audio_step(16'h7FFF, 1'b1);
         audio_step(16'h8000, 1'b0);
         audio_step(16'd8191, 1'b0);
         for (int i = 0; i < N_AUD; i++) begin
            r = next_random();
            audio_step({{2{r[13]}}, r[13:0]}, r[16]);
         end
         sample_once();
      end
      end_test("audio mix");

      $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run,
               u_checker.check_count, u_checker.error_count);
      if (u_checker.error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      #(N_ITEMS * 40 * 20);
      $display("Timeout: the tests did not finish within %0d ns", N_ITEMS * 40 * 20);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
msx_bus_pkg.sv
msx_slot_pkg.sv
cpu_bus_if.sv
msx_io_decoder.sv
msx_ppi.sv
msx_slot_select.sv
msx_keyboard_matrix.sv
msx_audio_mix.sv
msx_io_top.sv
tb_msx_checker.sv
tb_msx_io.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_msx_io
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run did not complete"; exit 1; fi
	@echo "Run finished without failure"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
